//--- verification/idctTests.txt
# name, then coefficients 0..15 in row order, then residuals 0..15 in row order
# all values are 16-bit two's complement hex
zeroBlock 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
dcSmall 0040 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
dcLarge 0100 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002
singleRowFreq 0000 0080 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0001 0001 0001 0001 0001 0001 0001 ffff ffff ffff ffff ffff ffff ffff ffff
singleColFreq 0000 0000 0000 0000 0040 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 ffff 0001 0000 0000 ffff 0001 0000 0000 ffff 0001 0000 0000 ffff
fullPositive 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 07b8 fe88 0178 0048 fd2a 008a ff76 ffe6 02d6 ff76 008a 001a 008b ffe6 001a 0005
fullNegative 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 f848 0178 fe88 ffb8 02d6 ff76 008a 001a fd2a 008a ff76 ffe6 ff75 001a ffe6 fffb

//--- sim.f
+incdir+hw
hw/busPkg.sv
hw/transformPkg.sv
hw/evenPart.sv
hw/oddPart.sv
hw/butterflyCombine.sv
hw/wbBlockInterface.sv
hw/transformSequencer.sv
hw/idctTop.sv
verification/idctTb.sv

//--- verification/idctTb.sv
module idctTb;

	localparam int MAX_TESTS = 32;
	localparam int POLL_LIMIT = 40;
	localparam int ACK_LIMIT = 4;
	// Directed checks rerun four lines of the file
	localparam int DIRECTED_RUNS = 4;

	logic clk;
	logic reset;
	busPkg::wbRequest busIn;
	busPkg::wbResponse busOut;

	integer seed;
	int testCount;
	int failCount;
	bit useGaps;
	bit testsLoaded;
	string nameTable [MAX_TESTS];
	logic [15:0] coefTable [MAX_TESTS][16];
	logic [15:0] expTable [MAX_TESTS][16];

	idctTop UUT
	(
		.clk(clk),
		.reset(reset),
		.busIn(busIn),
		.busOut(busOut)
	);

	always #4 clk = !clk;

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string testName, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else
		begin
			failCount++;
			$display("** Error: test %s expected %h actual %h", testName, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Mismatch in %s", testName);
		end
	endtask

	task automatic stopWithMessage(input string reason);
		failCount++;
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "Run stopped");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone host
	//////////////////////////////////////////////////////////////////////

	// Random idle cycles between transfers
	task automatic idleGap();
		int gap;
		gap = 0;
		if (useGaps)
			gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(posedge clk);
	endtask

	task automatic waitAck();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!busOut.ack && n < ACK_LIMIT);
		assert (busOut.ack)
		else
			stopWithMessage("The DUT did not acknowledge a bus transfer");
	endtask

	task automatic writeWord(input logic [5:0] addr, input logic [15:0] data);
		idleGap();
		@(posedge clk);
		busIn <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
		waitAck();
		@(posedge clk);
		busIn <= '0;
	endtask

	task automatic readWord(input logic [5:0] addr, output logic [15:0] data);
		idleGap();
		@(posedge clk);
		busIn <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 16'h0000};
		waitAck();
		data = busOut.dat;
		@(posedge clk);
		busIn <= '0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Block level steps
	//////////////////////////////////////////////////////////////////////

	task automatic loadBlock(input int t);
		for (int i = 0; i < 16; i++)
			writeWord(6'(i), coefTable[t][i]);
	endtask

	task automatic waitDone(input string testName);
		logic [15:0] status;
		int polls;
		polls = 0;
		status = '0;
		while (!status[1] && polls < POLL_LIMIT)
		begin
			readWord(6'h21, status);
			polls++;
		end
		if (!status[1])
			stopWithMessage({"Block never finished in test ", testName});
	endtask

	task automatic checkResults(input int t, input string testName);
		logic [15:0] value;
		for (int i = 0; i < 16; i++)
		begin
			readWord(6'h10 + 6'(i), value);
			checkValue(testName, expTable[t][i], value);
		end
	endtask

	task automatic runBlock(input int t);
		loadBlock(t);
		writeWord(6'h20, 16'h0001);
		waitDone(nameTable[t]);
		checkResults(t, nameTable[t]);
	endtask

	// Name, then sixteen coefficients and sixteen residuals per line
	task automatic loadTests();
		int fd;
		int code;
		string token;
		string rest;
		logic [15:0] value;
		fd = $fopen("verification/idctTests.txt", "r");
		if (fd == 0)
			stopWithMessage("Could not open the test data file");
		testCount = 0;
		while (!$feof(fd) && testCount < MAX_TESTS)
		begin
			code = $fscanf(fd, "%s", token);
			if (code == 1)
			begin
				if (token.getc(0) == "#")
					code = $fgets(rest, fd);
				else
				begin
					nameTable[testCount] = token;
					for (int i = 0; i < 32; i++)
					begin
						code = $fscanf(fd, "%h", value);
						if (i < 16)
							coefTable[testCount][i] = value;
						else
							expTable[testCount][i - 16] = value;
					end
					testCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		wait (testsLoaded);
		repeat (300 * (testCount + DIRECTED_RUNS) + 5) @(posedge clk);
		$display("Watchdog expired, the simulation ran too long");
		$display("TEST FAILED");
		$fatal(1, "Timeout");
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [15:0] value;
		clk = 1'b0;
		reset = 1'b1;
		busIn = '0;
		seed = 58;
		failCount = 0;
		useGaps = 1'b1;
		testCount = 0;

		loadTests();
		if (testCount < 7)
			stopWithMessage("The test data file holds too few blocks");
		testsLoaded = 1'b1;

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Idle state after reset
		readWord(6'h21, value);
		checkValue("resetStatus", 16'h0000, value);
		for (int i = 0; i < 16; i++)
		begin
			readWord(6'h10 + 6'(i), value);
			checkValue("resetResults", 16'h0000, value);
		end

		// Every block of the file, clipping blocks included
		for (int t = 0; t < testCount; t++)
			runBlock(t);

		// Writes while busy are dropped
		loadBlock(3);
		useGaps = 1'b0;
		writeWord(6'h20, 16'h0001);
		writeWord(6'h00, 16'h1234);
		writeWord(6'h05, 16'h4321);
		writeWord(6'h20, 16'h0001);
		writeWord(6'h0F, 16'h7777);
		useGaps = 1'b1;
		waitDone("busyWrites");
		checkResults(3, "busyWrites");
		for (int i = 0; i < 16; i++)
		begin
			readWord(6'(i), value);
			checkValue("busyWritesCoef", coefTable[3][i], value);
		end

		// Back to back blocks
		runBlock(5);
		loadBlock(6);
		writeWord(6'h20, 16'h0001);
		readWord(6'h21, value);
		checkValue("backToBackDone", 16'h0000, {14'h0000, value[1], 1'b0});
		waitDone("backToBack");
		checkResults(6, "backToBack");

		// Bank 3 and undefined registers
		writeWord(6'h33, 16'hFFFF);
		writeWord(6'h27, 16'hFFFF);
		writeWord(6'h22, 16'h0001);
		readWord(6'h21, value);
		checkValue("statusAfterJunk", 16'h0002, value);
		readWord(6'h30, value);
		checkValue("bank3Read", 16'h0000, value);
		readWord(6'h33, value);
		checkValue("bank3Read", 16'h0000, value);
		readWord(6'h27, value);
		checkValue("undefinedReg", 16'h0000, value);
		readWord(6'h2F, value);
		checkValue("undefinedReg", 16'h0000, value);
		for (int i = 0; i < 16; i++)
		begin
			readWord(6'(i), value);
			checkValue("coefAfterJunk", coefTable[6][i], value);
		end
		checkResults(6, "resultsAfterJunk");
		runBlock(1);

		if (failCount == 0)
		begin
			$display("TEST OK");
			$finish;
		end
		else
		begin
			$display("TEST FAILED");
			$fatal(1, "Checks failed");
		end
	end

endmodule

//--- hw/idctTop.sv
module idctTop
(
	input logic clk,
	input logic reset,
	input busPkg::wbRequest busIn,
	output busPkg::wbResponse busOut
);

	logic start;
	logic done;
	logic [1:0] coefRowIndex;
	transformPkg::sampleVector coefRow;
	logic resultWrite;
	logic [1:0] resultRowIndex;
	transformPkg::sampleVector resultRow;
	transformPkg::sampleVector inVector;
	transformPkg::passKind pass;
	transformPkg::evenResult evenValue;
	transformPkg::oddResult oddValue;
	transformPkg::sampleVector outVector;

	wbBlockInterface busSide
	(
		.clk(clk),
		.reset(reset),
		.busIn(busIn),
		.busOut(busOut),
		.start(start),
		.done(done),
		.coefRowIndex(coefRowIndex),
		.coefRow(coefRow),
		.resultWrite(resultWrite),
		.resultRowIndex(resultRowIndex),
		.resultRow(resultRow)
	);

	transformSequencer sequencer
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.coefRowIndex(coefRowIndex),
		.coefRow(coefRow),
		.inVector(inVector),
		.pass(pass),
		.outVector(outVector),
		.resultWrite(resultWrite),
		.resultRowIndex(resultRowIndex),
		.resultRow(resultRow)
	);

	// Even and odd halves run side by side
	evenPart evenHalf
	(
		.clk(clk),
		.reset(reset),
		.inVector(inVector),
		.even(evenValue)
	);

	oddPart oddHalf
	(
		.clk(clk),
		.reset(reset),
		.inVector(inVector),
		.odd(oddValue)
	);

	butterflyCombine combiner
	(
		.clk(clk),
		.reset(reset),
		.even(evenValue),
		.odd(oddValue),
		.pass(pass),
		.outVector(outVector)
	);

endmodule

//--- hw/transformSequencer.sv
`include "transform_settings.svh"

module transformSequencer
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic done,
	output logic [1:0] coefRowIndex,
	input transformPkg::sampleVector coefRow,
	output transformPkg::sampleVector inVector,
	output transformPkg::passKind pass,
	input transformPkg::sampleVector outVector,
	output logic resultWrite,
	output logic [1:0] resultRowIndex,
	output transformPkg::sampleVector resultRow
);

	// Datapath depth from inVector to outVector
	localparam int LATENCY = 2;
	localparam int COL_START = `BLOCK_SIZE + LATENCY;
	localparam int LAST_CYCLE = COL_START + `BLOCK_SIZE + LATENCY - 1;

	logic running;
	logic [3:0] cycleCount;
	logic [1:0] columnIndex;
	logic issueValid;
	logic [1:0] issueIndex;
	transformPkg::passKind issuePass;
	logic [LATENCY-1:0] stageValid;
	logic [1:0] stageIndex [LATENCY];
	transformPkg::passKind stagePass [LATENCY];
	logic rowReturn;
	logic signed [`SAMPLE_WIDTH-1:0] transposeBuf [`BLOCK_SIZE][`BLOCK_SIZE];

	//////////////////////////////////////////////////////////////////////
	// Schedule counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			running <= 1'b0;
			cycleCount <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= running && cycleCount == LAST_CYCLE;
			if (start)
			begin
				running <= 1'b1;
				cycleCount <= '0;
			end
			else if (running)
			begin
				if (cycleCount == LAST_CYCLE)
				begin
					running <= 1'b0;
					cycleCount <= '0;
				end
				else
					cycleCount <= cycleCount + 4'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Issue side
	//////////////////////////////////////////////////////////////////////

	assign coefRowIndex = cycleCount[1:0];
	assign columnIndex = 2'(cycleCount - COL_START);

	always_comb
	begin
		issueValid = 1'b0;
		issueIndex = coefRowIndex;
		issuePass = transformPkg::rowPass;
		inVector = coefRow;
		if (running && cycleCount < `BLOCK_SIZE)
			issueValid = 1'b1;
		else if (running && cycleCount >= COL_START && cycleCount < COL_START + `BLOCK_SIZE)
		begin
			// Row of the transpose buffer is a column of the row-pass output
			issueValid = 1'b1;
			issueIndex = columnIndex;
			issuePass = transformPkg::columnPass;
			inVector.s0 = transposeBuf[columnIndex][0];
			inVector.s1 = transposeBuf[columnIndex][1];
			inVector.s2 = transposeBuf[columnIndex][2];
			inVector.s3 = transposeBuf[columnIndex][3];
		end
	end

	// Tags follow each vector through the two datapath stages
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			stageValid <= '0;
			for (int i = 0; i < LATENCY; i++)
			begin
				stageIndex[i] <= '0;
				stagePass[i] <= transformPkg::rowPass;
			end
		end
		else
		begin
			stageValid <= {stageValid[0], issueValid};
			stageIndex[0] <= issueIndex;
			stageIndex[1] <= stageIndex[0];
			stagePass[0] <= issuePass;
			stagePass[1] <= stagePass[0];
		end
	end

	// Butterfly stage sees the vector issued one cycle earlier
	assign pass = stagePass[0];

	//////////////////////////////////////////////////////////////////////
	// Return side
	//////////////////////////////////////////////////////////////////////

	assign rowReturn = stageValid[1] && stagePass[1] == transformPkg::rowPass;
	assign resultWrite = stageValid[1] && stagePass[1] == transformPkg::columnPass;
	assign resultRowIndex = stageIndex[1];
	assign resultRow = outVector;

	// Row results are stored as columns
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int r = 0; r < `BLOCK_SIZE; r++)
				for (int c = 0; c < `BLOCK_SIZE; c++)
					transposeBuf[r][c] <= '0;
		end
		else if (rowReturn)
		begin
			transposeBuf[0][stageIndex[1]] <= outVector.s0;
			transposeBuf[1][stageIndex[1]] <= outVector.s1;
			transposeBuf[2][stageIndex[1]] <= outVector.s2;
			transposeBuf[3][stageIndex[1]] <= outVector.s3;
		end
	end

	resultWindow: assert property (@(posedge clk) disable iff (reset)
		resultWrite |-> running && cycleCount >= COL_START + LATENCY
			&& cycleCount <= LAST_CYCLE)
		else $error("transformSequencer: result write outside cycles 8 to 11");

endmodule

//--- hw/wbBlockInterface.sv
`include "transform_settings.svh"

module wbBlockInterface
(
	input logic clk,
	input logic reset,
	input busPkg::wbRequest busIn,
	output busPkg::wbResponse busOut,
	output logic start,
	input logic done,
	input logic [1:0] coefRowIndex,
	output transformPkg::sampleVector coefRow,
	input logic resultWrite,
	input logic [1:0] resultRowIndex,
	input transformPkg::sampleVector resultRow
);

	localparam int WORDS = `BLOCK_SIZE * `BLOCK_SIZE;

	busPkg::wbAddress addr;
	logic active;
	logic accept;
	logic blocked;
	logic startWrite;
	logic coefWrite;
	logic [3:0] wordIndex;
	logic [`WB_DATA_WIDTH-1:0] readData;
	logic [`WB_DATA_WIDTH-1:0] coefBuf [WORDS];
	logic [`WB_DATA_WIDTH-1:0] resultBuf [WORDS];
	logic busyFlag;
	logic doneFlag;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	assign addr = busIn.adr;
	assign wordIndex = {addr.bufferView.row, addr.bufferView.col};

	// Single-cycle ack, so a held request is taken once
	assign active = busIn.cyc && busIn.stb;
	assign accept = active && !busOut.ack;

	// A start in flight counts as busy too
	assign blocked = busyFlag || start;

	assign startWrite = accept && busIn.we && busIn.dat[0]
		&& addr.controlView.bank == busPkg::BANK_CONTROL
		&& addr.controlView.regIndex == busPkg::REG_CONTROL;

	assign coefWrite = accept && busIn.we && !blocked
		&& addr.bufferView.bank == busPkg::BANK_COEF;

	always_comb
	begin
		case (addr.bufferView.bank)
			busPkg::BANK_COEF: readData = coefBuf[wordIndex];
			busPkg::BANK_RESULT: readData = resultBuf[wordIndex];
			busPkg::BANK_CONTROL:
			begin
				if (addr.controlView.regIndex == busPkg::REG_STATUS)
					readData = {{(`WB_DATA_WIDTH - 2){1'b0}}, doneFlag, busyFlag};
				else
					readData = '0;
			end
			default: readData = '0;
		endcase
	end

	// Row read for the sequencer
	assign coefRow.s0 = coefBuf[{coefRowIndex, 2'd0}];
	assign coefRow.s1 = coefBuf[{coefRowIndex, 2'd1}];
	assign coefRow.s2 = coefBuf[{coefRowIndex, 2'd2}];
	assign coefRow.s3 = coefBuf[{coefRowIndex, 2'd3}];

	//////////////////////////////////////////////////////////////////////
	// Bus response, buffers and status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			busOut <= '0;
			start <= 1'b0;
			busyFlag <= 1'b0;
			doneFlag <= 1'b0;
			for (int i = 0; i < WORDS; i++)
			begin
				coefBuf[i] <= '0;
				resultBuf[i] <= '0;
			end
		end
		else
		begin
			busOut.ack <= accept;
			if (accept)
				busOut.dat <= readData;

			start <= startWrite && !blocked;
			if (startWrite && !blocked)
				doneFlag <= 1'b0;
			if (start)
				busyFlag <= 1'b1;

			// End of the column pass
			if (done)
			begin
				busyFlag <= 1'b0;
				doneFlag <= 1'b1;
			end

			if (coefWrite)
				coefBuf[wordIndex] <= busIn.dat;

			if (resultWrite)
			begin
				resultBuf[{resultRowIndex, 2'd0}] <= resultRow.s0;
				resultBuf[{resultRowIndex, 2'd1}] <= resultRow.s1;
				resultBuf[{resultRowIndex, 2'd2}] <= resultRow.s2;
				resultBuf[{resultRowIndex, 2'd3}] <= resultRow.s3;
			end
		end
	end

	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		busOut.ack |-> busIn.cyc && busIn.stb)
		else $error("wbBlockInterface: ack without an active cycle");

	doneOnlyFromBusy: assert property (@(posedge clk) disable iff (reset)
		$rose(doneFlag) |-> $past(busyFlag))
		else $error("wbBlockInterface: done rose while idle");

endmodule

//--- hw/butterflyCombine.sv
`include "transform_settings.svh"

module butterflyCombine
(
	input logic clk,
	input logic reset,
	input transformPkg::evenResult even,
	input transformPkg::oddResult odd,
	input transformPkg::passKind pass,
	output transformPkg::sampleVector outVector
);

	localparam logic signed [`ACC_WIDTH-1:0] SAMPLE_MAX = 2 ** (`SAMPLE_WIDTH - 1) - 1;
	localparam logic signed [`ACC_WIDTH-1:0] SAMPLE_MIN = -(2 ** (`SAMPLE_WIDTH - 1));

	// Round, shift and saturate one butterfly output
	function automatic logic signed [`SAMPLE_WIDTH-1:0] scaleClip
	(
		input logic signed [`ACC_WIDTH-1:0] value,
		input transformPkg::passKind kind
	);
		logic signed [`ACC_WIDTH-1:0] shifted;
		if (kind == transformPkg::rowPass)
			shifted = (value + `ROW_ROUND) >>> `ROW_SHIFT;
		else
			shifted = (value + `COL_ROUND) >>> `COL_SHIFT;
		if (shifted > SAMPLE_MAX)
			shifted = SAMPLE_MAX;
		else if (shifted < SAMPLE_MIN)
			shifted = SAMPLE_MIN;
		return shifted[`SAMPLE_WIDTH-1:0];
	endfunction

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			outVector <= '0;
		end
		else
		begin
			outVector.s0 <= scaleClip(even.e0 + odd.o0, pass);
			outVector.s1 <= scaleClip(even.e1 + odd.o1, pass);
			outVector.s2 <= scaleClip(even.e1 - odd.o1, pass);
			outVector.s3 <= scaleClip(even.e0 - odd.o0, pass);
		end
	end

	// Pass comes from the sequencer, aligned with this stage
	passKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(pass))
		else $error("butterflyCombine: pass is unknown");

endmodule

//--- hw/oddPart.sv
`include "transform_settings.svh"

module oddPart
(
	input logic clk,
	input logic reset,
	input transformPkg::sampleVector inVector,
	output transformPkg::oddResult odd
);

	logic signed [`ACC_WIDTH-1:0] sample1;
	logic signed [`ACC_WIDTH-1:0] sample3;
	logic signed [`ACC_WIDTH-1:0] odd0;
	logic signed [`ACC_WIDTH-1:0] odd1;

	assign sample1 = inVector.s1;
	assign sample3 = inVector.s3;

	// Rotation of the odd samples by the two kernel constants
	assign odd0 = `COEF_B * sample1 + `COEF_C * sample3;
	assign odd1 = `COEF_C * sample1 - `COEF_B * sample3;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			odd <= '0;
		end
		else
		begin
			odd.o0 <= odd0;
			odd.o1 <= odd1;
		end
	end

endmodule

//--- hw/evenPart.sv
`include "transform_settings.svh"

module evenPart
(
	input logic clk,
	input logic reset,
	input transformPkg::sampleVector inVector,
	output transformPkg::evenResult even
);

	logic signed [`ACC_WIDTH-1:0] sample0;
	logic signed [`ACC_WIDTH-1:0] sample2;

	// Widen first so full-scale inputs cannot wrap in the sum
	assign sample0 = inVector.s0;
	assign sample2 = inVector.s2;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			even <= '0;
		end
		else
		begin
			even.e0 <= `COEF_A * (sample0 + sample2);
			even.e1 <= `COEF_A * (sample0 - sample2);
		end
	end

endmodule

//--- hw/transformPkg.sv
`include "transform_settings.svh"

package transformPkg;

	// One row or column of a block
	typedef struct packed
	{
		logic signed [`SAMPLE_WIDTH-1:0] s0;
		logic signed [`SAMPLE_WIDTH-1:0] s1;
		logic signed [`SAMPLE_WIDTH-1:0] s2;
		logic signed [`SAMPLE_WIDTH-1:0] s3;
	} sampleVector;

	// Even half, from samples 0 and 2
	typedef struct packed
	{
		logic signed [`ACC_WIDTH-1:0] e0;
		logic signed [`ACC_WIDTH-1:0] e1;
	} evenResult;

	// Odd half, from samples 1 and 3
	typedef struct packed
	{
		logic signed [`ACC_WIDTH-1:0] o0;
		logic signed [`ACC_WIDTH-1:0] o1;
	} oddResult;

	typedef enum logic
	{
		rowPass,
		columnPass
	} passKind;

endpackage

//--- hw/busPkg.sv
`include "transform_settings.svh"

package busPkg;

	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_ADDR_WIDTH-1:0] adr;
		logic [`WB_DATA_WIDTH-1:0] dat;
	} wbRequest;

	typedef struct packed
	{
		logic ack;
		logic [`WB_DATA_WIDTH-1:0] dat;
	} wbResponse;

	// Word address seen as a buffer location
	typedef struct packed
	{
		logic [1:0] bank;
		logic [1:0] row;
		logic [1:0] col;
	} bufferAddress;

	// Same word seen as a control register index
	typedef struct packed
	{
		logic [1:0] bank;
		logic [3:0] regIndex;
	} controlAddress;

	typedef union packed
	{
		bufferAddress bufferView;
		controlAddress controlView;
	} wbAddress;

	localparam logic [1:0] BANK_COEF = 2'd0;
	localparam logic [1:0] BANK_RESULT = 2'd1;
	localparam logic [1:0] BANK_CONTROL = 2'd2;

	localparam logic [3:0] REG_CONTROL = 4'd0;
	localparam logic [3:0] REG_STATUS = 4'd1;

endpackage

//--- hw/transform_settings.svh
`ifndef TRANSFORM_SETTINGS_SVH
`define TRANSFORM_SETTINGS_SVH

// Sample and accumulator widths
`define SAMPLE_WIDTH 16
`define ACC_WIDTH 32

// Samples on one side of a block
`define BLOCK_SIZE 4

// First pass (rows) and second pass (columns)
`define ROW_ROUND 64
`define ROW_SHIFT 7
`define COL_ROUND 2048
`define COL_SHIFT 12

// 4-point kernel constants
`define COEF_A 64
`define COEF_B 83
`define COEF_C 36

// Wishbone
`define WB_ADDR_WIDTH 6
`define WB_DATA_WIDTH 16

`endif
